// File: include/softmax_cfg.svh
`ifndef SOFTMAX_CFG_SVH
`define SOFTMAX_CFG_SVH

// ========================================
// Softmax stage configuration
// ========================================

// Input exponent width, 2^e spans 2^SM_EXP_W values
`define SM_EXP_W          4

// Graph shape
`define SM_MAX_NODES      8
`define SM_NUM_SUBGRAPHS  16

// Alpha format, 1.15 unsigned
`define SM_WOI            1
`define SM_WOF            15

// Alignment stage + one stage per quotient bit + two output registers
`define SM_DIV_LATENCY    (`SM_WOI + `SM_WOF + 3)

// FIFO depths
`define SM_IN_DEPTH       16
`define SM_OUT_DEPTH      32
`define SM_DIVD_DEPTH     32
`define SM_DVSR_DEPTH     8

`endif

// File: rtl/fifo_if.sv
`default_nettype none

interface fifo_if #(
  parameter int DATA_W = 8,
  parameter int DEPTH  = 16
);

  localparam int CNT_W = $clog2(DEPTH + 1);

  // Write side
  logic [DATA_W-1:0] din;
  logic              wr;
  logic              full;

  // Read side, first word falls through
  logic [DATA_W-1:0] dout;
  logic              empty;
  logic              rd;

  logic [CNT_W-1:0]  count;

  modport producer (output din, output wr, input full, input count);
  modport consumer (input dout, input empty, output rd, input count);
  modport fifo (input din, input wr, output full, output dout, output empty,
                input rd, output count);

endinterface

`default_nettype wire

// File: rtl/fxp_div_pipe.sv
`default_nettype none

`include "softmax_cfg.svh"

module fxp_div_pipe (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_vld,
  input  softmax_data_pkg::pow_t  dividend,
  input  softmax_data_pkg::sum_t  divisor,
  output logic                    out_vld,
  output softmax_data_pkg::alpha_t quotient
);

  import softmax_data_pkg::*;

  localparam int QW    = `SM_WOI + `SM_WOF;
  localparam int DV_W  = $bits(sum_t);
  localparam int NUM_W = $bits(pow_t) + `SM_WOF;

  // Scaled numerator, dividend * 2^WOF
  logic [NUM_W-1:0] num;

  logic [DV_W-1:0]  rem_s  [QW];
  logic [QW-1:0]    bits_s [QW];
  sum_t             dvsr_s [QW];
  logic [QW-1:0]    q_s    [QW];
  logic [QW:0]      vld_s;

  logic [DV_W:0]    trial  [QW];
  logic [DV_W-1:0]  rem_nx [QW-1];
  logic [QW-1:0]    ge;

  alpha_t           q_out1;
  logic             vld_out1;

  assign num = NUM_W'(dividend) << `SM_WOF;

  // ========================================
  // Restoring step per stage
  // ========================================
  always_comb begin
    for (int k = 0; k < QW; k++) begin
      trial[k] = {rem_s[k], bits_s[k][QW-1]};
      ge[k]    = (trial[k] >= {1'b0, dvsr_s[k]});
    end
    for (int k = 0; k < QW - 1; k++) begin
      rem_nx[k] = ge[k] ? DV_W'(trial[k] - {1'b0, dvsr_s[k]}) : trial[k][DV_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    // Alignment, upper bits preload the remainder
    // Quotient fits QW bits only while dividend <= divisor
    rem_s[0]  <= DV_W'(num[NUM_W-1:QW]);
    bits_s[0] <= num[QW-1:0];
    dvsr_s[0] <= divisor;

    q_s[0] <= QW'(ge[0]);
    for (int k = 1; k < QW; k++) begin
      q_s[k] <= {q_s[k-1][QW-2:0], ge[k]};
    end
    for (int k = 0; k < QW - 1; k++) begin
      rem_s[k+1]  <= rem_nx[k];
      bits_s[k+1] <= bits_s[k] << 1;
      dvsr_s[k+1] <= dvsr_s[k];
    end

    // Two output stages
    q_out1   <= q_s[QW-1];
    quotient <= q_out1;
  end

  // Valid travels with the data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_s    <= '0;
      vld_out1 <= 1'b0;
      out_vld  <= 1'b0;
    end else begin
      vld_s    <= {vld_s[QW-1:0], in_vld};
      vld_out1 <= vld_s[QW];
      out_vld  <= vld_out1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/graph_pkg.sv
`default_nettype none

`include "softmax_cfg.svh"

package graph_pkg;

  typedef logic [$clog2(`SM_MAX_NODES + 1)-1:0] node_cnt_t;
  typedef logic [$clog2(`SM_NUM_SUBGRAPHS)-1:0] sg_addr_t;

  // Accumulate side of the softmax block
  typedef enum logic [1:0] {
    fetch_count,
    accumulate,
    push_sum
  } sm_state_t;

endpackage

`default_nettype wire

// File: rtl/num_node_table.sv
`default_nettype none

`include "softmax_cfg.svh"

module num_node_table (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wr,
  input  graph_pkg::sg_addr_t  waddr,
  input  graph_pkg::node_cnt_t wdata,
  input  graph_pkg::sg_addr_t  raddr,
  output graph_pkg::node_cnt_t rdata
);

  import graph_pkg::*;

  node_cnt_t mem [`SM_NUM_SUBGRAPHS];

  // Host side, only written while the stage is idle
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[waddr] <= wdata;
    end
  end

  // One cycle read latency
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else begin
      rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

// File: rtl/softmax.sv
`default_nettype none

`include "softmax_cfg.svh"

module softmax (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 sm_en,
  fifo_if.consumer             coef,
  fifo_if.producer             alpha,
  output graph_pkg::sg_addr_t  tbl_addr,
  input  graph_pkg::node_cnt_t tbl_count
);

  import softmax_data_pkg::*;
  import graph_pkg::*;

  localparam int DVSR_W = $bits(node_cnt_t) + $bits(sum_t);
  localparam int CNT_W  = $clog2(`SM_OUT_DEPTH + 1);
  localparam int CMT_W  = CNT_W + 1;

  fifo_if #(.DATA_W($bits(pow_t)), .DEPTH(`SM_DIVD_DEPTH)) divd_if ();
  fifo_if #(.DATA_W(DVSR_W), .DEPTH(`SM_DVSR_DEPTH)) dvsr_if ();

  sm_state_t        state;
  sg_addr_t         sg_addr;
  node_cnt_t        node_cnt;
  sum_t             sum;
  pow_t             pow;
  logic             consume;
  logic             last_node;

  node_cnt_t        div_rem;
  sum_t             cur_dvsr;
  node_cnt_t        new_cnt;
  sum_t             new_sum;
  sum_t             div_dvsr;
  logic             need_load;
  logic             credit_ok;
  logic             issue;
  logic [CNT_W-1:0] in_flight;
  logic [CMT_W-1:0] committed;
  logic             div_out_vld;
  alpha_t           div_q;

  sync_fifo #(.DATA_W($bits(pow_t)), .DEPTH(`SM_DIVD_DEPTH)) u_divd_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .f     (divd_if)
  );

  sync_fifo #(.DATA_W(DVSR_W), .DEPTH(`SM_DVSR_DEPTH)) u_dvsr_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .f     (dvsr_if)
  );

  // ========================================
  // Exponent and sum
  // ========================================
  assign tbl_addr  = sg_addr;
  assign pow       = pow_t'(1) << coef.dout;
  assign last_node = (node_cnt == tbl_count - node_cnt_t'(1));
  assign consume   = (state == accumulate) && sm_en && !coef.empty && !divd_if.full;

  assign coef.rd     = consume;
  assign divd_if.wr  = consume;
  assign divd_if.din = pow;
  assign dvsr_if.wr  = (state == push_sum) && !dvsr_if.full;
  assign dvsr_if.din = {tbl_count, sum};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= fetch_count;
      sg_addr  <= '0;
      node_cnt <= '0;
    end else begin
      case (state)
        // Table read is in flight for the new address
        fetch_count: if (sm_en) state <= accumulate;
        accumulate: begin
          if (consume) begin
            if (last_node) begin
              node_cnt <= '0;
              state    <= push_sum;
            end else begin
              node_cnt <= node_cnt + node_cnt_t'(1);
            end
          end
        end
        push_sum: begin
          if (dvsr_if.wr) begin
            sg_addr <= sg_addr + sg_addr_t'(1);
            state   <= fetch_count;
          end
        end
        default: state <= fetch_count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (consume) begin
      sum <= (node_cnt == '0) ? sum_t'(pow) : sum + sum_t'(pow);
    end
  end

  // ========================================
  // Division scheduling
  // ========================================
  assign {new_cnt, new_sum} = dvsr_if.dout;
  assign need_load = (div_rem == '0);
  assign div_dvsr  = need_load ? new_sum : cur_dvsr;

  // Room in the alpha FIFO for everything already issued
  assign committed = {1'b0, alpha.count} + {1'b0, in_flight};
  assign credit_ok = (committed < CMT_W'(`SM_OUT_DEPTH));
  assign issue     = (!need_load || !dvsr_if.empty) && !divd_if.empty && credit_ok;

  assign divd_if.rd = issue;
  assign dvsr_if.rd = issue && need_load;

  always_ff @(posedge clk) begin
    if (dvsr_if.rd) begin
      cur_dvsr <= new_sum;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_rem   <= '0;
      in_flight <= '0;
    end else begin
      if (issue) begin
        div_rem <= (need_load ? new_cnt : div_rem) - node_cnt_t'(1);
      end
      case ({issue, div_out_vld})
        2'b10:   in_flight <= in_flight + CNT_W'(1);
        2'b01:   in_flight <= in_flight - CNT_W'(1);
        default: in_flight <= in_flight;
      endcase
    end
  end

  fxp_div_pipe u_div (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_vld   (issue),
    .dividend (divd_if.dout),
    .divisor  (div_dvsr),
    .out_vld  (div_out_vld),
    .quotient (div_q)
  );

  // Credit rule keeps this write from ever hitting a full FIFO
  assign alpha.wr  = div_out_vld;
  assign alpha.din = div_q;

endmodule

`default_nettype wire

// File: rtl/softmax_data_pkg.sv
`default_nettype none

`include "softmax_cfg.svh"

package softmax_data_pkg;

  // 2^e needs one bit per possible exponent value
  localparam int POW_W   = 1 << `SM_EXP_W;
  localparam int SUM_W   = POW_W + $clog2(`SM_MAX_NODES);
  localparam int ALPHA_W = `SM_WOI + `SM_WOF;

  typedef logic [`SM_EXP_W-1:0] exp_t;
  typedef logic [POW_W-1:0]     pow_t;
  typedef logic [SUM_W-1:0]     sum_t;
  typedef logic [ALPHA_W-1:0]   alpha_t;

endpackage

`default_nettype wire

// File: rtl/softmax_top.sv
`default_nettype none

`include "softmax_cfg.svh"

module softmax_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     sm_en,
  input  logic                     coef_wr,
  input  softmax_data_pkg::exp_t   coef_din,
  output logic                     coef_full,
  input  logic                     tbl_wr,
  input  graph_pkg::sg_addr_t      tbl_waddr,
  input  graph_pkg::node_cnt_t     tbl_wdata,
  input  logic                     alpha_rd,
  output softmax_data_pkg::alpha_t alpha_dout,
  output logic                     alpha_empty
);

  import softmax_data_pkg::*;
  import graph_pkg::*;

  sg_addr_t  tbl_raddr;
  node_cnt_t tbl_rdata;

  fifo_if #(.DATA_W($bits(exp_t)), .DEPTH(`SM_IN_DEPTH)) coef_if ();
  fifo_if #(.DATA_W($bits(alpha_t)), .DEPTH(`SM_OUT_DEPTH)) alpha_if ();

  // Host side of the two FIFOs
  assign coef_if.din  = coef_din;
  assign coef_if.wr   = coef_wr;
  assign coef_full    = coef_if.full;
  assign alpha_if.rd  = alpha_rd;
  assign alpha_dout   = alpha_if.dout;
  assign alpha_empty  = alpha_if.empty;

  sync_fifo #(.DATA_W($bits(exp_t)), .DEPTH(`SM_IN_DEPTH)) u_coef_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .f     (coef_if)
  );

  num_node_table u_num_node_table (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (tbl_wr),
    .waddr (tbl_waddr),
    .wdata (tbl_wdata),
    .raddr (tbl_raddr),
    .rdata (tbl_rdata)
  );

  softmax u_softmax (
    .clk       (clk),
    .rst_n     (rst_n),
    .sm_en     (sm_en),
    .coef      (coef_if),
    .alpha     (alpha_if),
    .tbl_addr  (tbl_raddr),
    .tbl_count (tbl_rdata)
  );

  sync_fifo #(.DATA_W($bits(alpha_t)), .DEPTH(`SM_OUT_DEPTH)) u_alpha_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .f     (alpha_if)
  );

endmodule

`default_nettype wire

// File: rtl/sync_fifo.sv
`default_nettype none

module sync_fifo #(
  parameter int DATA_W = 8,
  parameter int DEPTH  = 16
) (
  input  logic clk,
  input  logic rst_n,
  fifo_if.fifo f
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wptr;
  logic [PTR_W-1:0]  rptr;
  logic [CNT_W-1:0]  count;
  logic              do_wr;
  logic              do_rd;

  // Writes while full and reads while empty are dropped
  assign do_wr = f.wr && (count != CNT_W'(DEPTH));
  assign do_rd = f.rd && (count != '0);

  assign f.full  = (count == CNT_W'(DEPTH));
  assign f.empty = (count == '0);
  assign f.count = count;
  assign f.dout  = mem[rptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wptr] <= f.din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (do_wr) begin
        wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + PTR_W'(1);
      end
      if (do_rd) begin
        rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + PTR_W'(1);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the softmax testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
  --top-module tb_softmax -o tb_softmax_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_softmax_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "Simulation returned an error status"
  exit 1
fi
cat sim.log

if grep -q "^SIMULATION PASSED$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: tb/tb_softmax.sv
`default_nettype none

`include "softmax_cfg.svh"

module tb_softmax;

  timeunit 1ns;
  timeprecision 1ps;

  import softmax_data_pkg::*;
  import graph_pkg::*;

  localparam int NUM_SG     = `SM_NUM_SUBGRAPHS;
  localparam int PRE_WRITES = 4;
  localparam int STALL_MAX  = 300;

  logic      clk;
  logic      rst_n;
  logic      sm_en;
  logic      coef_wr;
  exp_t      coef_din;
  logic      coef_full;
  logic      tbl_wr;
  sg_addr_t  tbl_waddr;
  node_cnt_t tbl_wdata;
  logic      alpha_rd;
  alpha_t    alpha_dout;
  logic      alpha_empty;

  int        counts [NUM_SG];
  exp_t      exps [$];
  alpha_t    exp_q [$];
  alpha_t    got1 [$];
  int        total;
  int        sg1_n;
  int        coef_writes = 0;
  int        errors = 0;
  int        checks = 0;
  int        cycles = 0;
  int        cycle_limit = 100000;

  softmax_top dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .sm_en       (sm_en),
    .coef_wr     (coef_wr),
    .coef_din    (coef_din),
    .coef_full   (coef_full),
    .tbl_wr      (tbl_wr),
    .tbl_waddr   (tbl_waddr),
    .tbl_wdata   (tbl_wdata),
    .alpha_rd    (alpha_rd),
    .alpha_dout  (alpha_dout),
    .alpha_empty (alpha_empty)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // ========================================
  // Reference model
  // ========================================
  // Subgraph 0 has one neighbor and subgraph 1 has equal exponents
  task automatic build_stimulus();
    int n;
    int base;
    int e_eq;
    longint unsigned sum;
    total = 0;
    for (int s = 0; s < NUM_SG; s++) begin
      if (s == 0) n = 1;
      else if (s == 1) n = $urandom_range(2, `SM_MAX_NODES);
      else n = $urandom_range(1, `SM_MAX_NODES);
      counts[s] = n;
      e_eq = $urandom_range(0, 15);
      base = exps.size();
      for (int k = 0; k < n; k++) begin
        exps.push_back((s == 1) ? exp_t'(e_eq) : exp_t'($urandom_range(0, 15)));
      end
      sum = 0;
      for (int k = 0; k < n; k++) begin
        sum += 64'd1 << exps[base + k];
      end
      // Truncated quotient in 1.15 format
      for (int k = 0; k < n; k++) begin
        exp_q.push_back(alpha_t'(((64'd1 << exps[base + k]) << `SM_WOF) / sum));
      end
      total += n;
    end
    sg1_n = counts[1];
  endtask

  task automatic load_table();
    for (int s = 0; s < NUM_SG; s++) begin
      tbl_wr    = 1'b1;
      tbl_waddr = sg_addr_t'(s);
      tbl_wdata = node_cnt_t'(counts[s]);
      @(negedge clk);
    end
    tbl_wr = 1'b0;
  endtask

  // ========================================
  // Host side drivers entered on a falling edge
  // ========================================
  // Held until the FIFO has room
  task automatic write_coef(input exp_t e);
    bit accepted;
    accepted = 1'b0;
    coef_din = e;
    coef_wr  = 1'b1;
    while (!accepted) begin
      // coef_full only changes on a rising edge
      accepted = !coef_full;
      if (accepted) begin
        coef_writes++;
      end
      @(negedge clk);
    end
    coef_wr = 1'b0;
  endtask

  task automatic write_coefs(input int first, input bit bursty);
    for (int i = first; i < total; i++) begin
      if (bursty && $urandom_range(0, 2) == 0) begin
        repeat ($urandom_range(1, 4)) @(negedge clk);
      end
      write_coef(exps[i]);
    end
  endtask

  // Start the stage only once the input FIFO has filled
  task automatic enable_when_full();
    while (!coef_full) begin
      @(negedge clk);
    end
    check_value(64'(coef_writes), 64'(`SM_IN_DEPTH), "writes accepted before coef_full");
    repeat (4) @(negedge clk);
    sm_en = 1'b1;
  endtask

  task automatic read_alphas(input bit second, input int stall_at, input int stall_len);
    int n;
    n = 0;
    while (n < total) begin
      if (second && n == stall_at && stall_len > 0) begin
        alpha_rd = 1'b0;
        repeat (stall_len) @(negedge clk);
        stall_len = 0;
      end
      if (!alpha_empty && (!second || $urandom_range(0, 1) == 1)) begin
        check_value(64'(alpha_dout), 64'(exp_q[n]), $sformatf("alpha %0d", n));
        if (second) begin
          check_value(64'(alpha_dout), 64'(got1[n]), $sformatf("alpha %0d vs first run", n));
        end else begin
          got1.push_back(alpha_dout);
        end
        alpha_rd = 1'b1;
        n++;
      end else begin
        alpha_rd = 1'b0;
      end
      @(negedge clk);
    end
    alpha_rd = 1'b0;
  endtask

  // Nothing extra may show up once every result is read
  task automatic check_drained(input string what);
    repeat (`SM_DIV_LATENCY + 10) @(negedge clk);
    check_value(64'(alpha_empty), 64'd1, what);
  endtask

  // ========================================
  // Timeout
  // ========================================
  initial begin
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not complete within %0d clock cycles", cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int stall_at;
    int stall_len;
    void'($urandom(32'h1965));
    rst_n     = 1'b0;
    sm_en     = 1'b0;
    coef_wr   = 1'b0;
    coef_din  = '0;
    tbl_wr    = 1'b0;
    tbl_waddr = '0;
    tbl_wdata = '0;
    alpha_rd  = 1'b0;

    build_stimulus();
    cycle_limit = 2 * total * 12 + STALL_MAX + 4 * `SM_DIV_LATENCY + 400;

    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    check_value(64'(alpha_empty), 64'd1, "alpha_empty after reset");
    check_value(64'(coef_full), 64'd0, "coef_full after reset");

    load_table();

    // A few exponents while the stage is disabled
    for (int i = 0; i < PRE_WRITES; i++) begin
      write_coef(exps[i]);
    end
    repeat (2 * `SM_DIV_LATENCY) begin
      check_value(64'(alpha_empty), 64'd1, "alpha_empty with sm_en low");
      @(negedge clk);
    end
    sm_en = 1'b1;

    // Continuous writes and reads
    fork
      write_coefs(PRE_WRITES, 1'b0);
      read_alphas(1'b0, 0, 0);
    join
    check_drained("alpha_empty after first run");

    // Same stream with bursty writes, a full input FIFO and a long reader stall
    sm_en       = 1'b0;
    coef_writes = 0;
    stall_at    = $urandom_range(0, 4);
    stall_len   = $urandom_range(150, STALL_MAX);
    fork
      write_coefs(0, 1'b1);
      read_alphas(1'b1, stall_at, stall_len);
      enable_when_full();
    join
    check_drained("alpha_empty after second run");

    check_value(64'(got1[0]), 64'd1 << `SM_WOF, "single neighbor alpha");
    for (int k = 1; k <= sg1_n; k++) begin
      check_value(64'(got1[k]), (64'd1 << `SM_WOF) / 64'(sg1_n), "equal exponent alpha");
    end

    $display("Neighbors: %0d  checks: %0d  errors: %0d", total, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
rtl/softmax_data_pkg.sv
rtl/graph_pkg.sv
rtl/fifo_if.sv
rtl/sync_fifo.sv
rtl/num_node_table.sv
rtl/fxp_div_pipe.sv
rtl/softmax.sv
rtl/softmax_top.sv
tb/tb_softmax.sv
